/* logic/coh_pkg.sv */
package coh_pkg;
    // sizes and counts
    localparam int CPUS           = 4;
    localparam int CPU_ID_W       = 2;
    localparam int BLOCK_WORDS    = 2;
    localparam int BLOCK_OFFSET_W = 3;      // byte offset inside a block
    localparam int L1_SETS        = 4;
    localparam int L1_INDEX_W     = 2;
    localparam int L1_TAG_W       = 32 - BLOCK_OFFSET_W - L1_INDEX_W;
    localparam int L2_BLOCKS      = 64;
    localparam int L2_INDEX_W     = 6;
    localparam int L2_LATENCY     = 3;      // request start to L2_ACCESS
    localparam int L2_CNT_W       = 2;

    typedef logic [31:0] word_t;
    typedef word_t [BLOCK_WORDS-1:0] block_t;
    typedef logic [CPU_ID_W-1:0] cpu_id_t;
    typedef logic [L1_INDEX_W-1:0] l1_idx_t;
    typedef logic [L1_TAG_W-1:0] l1_tag_t;
    typedef logic [L2_INDEX_W-1:0] l2_idx_t;
    typedef logic [L2_CNT_W-1:0] l2_cnt_t;
    typedef logic [BLOCK_OFFSET_W-1:0] blk_off_t;

    localparam word_t BLOCK_MASK = ~word_t'((1 << BLOCK_OFFSET_W) - 1);
    localparam l2_cnt_t L2_LAST  = l2_cnt_t'(L2_LATENCY - 1);

    typedef enum logic [3:0] {
        IDLE, GRANT_R, GRANT_RX, GRANT_EVICT, GRANT_INV,
        SNOOP_R, SNOOP_RX, SNOOP_INV, TRANSFER_R, TRANSFER_RX,
        READ_L2, WRITEBACK_MS, WRITEBACK, BUS_TO_CACHE, INVALIDATE
    } bus_state_t;

    typedef enum logic [1:0] {L2_FREE, L2_BUSY, L2_ACCESS} l2_state_t;
    typedef enum logic [1:0] {M, E, S, I} mesi_t;
    typedef enum logic {OP_READ, OP_WRITE} cpu_op_e;

    // private cache controller
    typedef enum logic [2:0] {
        AG_IDLE, AG_LOOKUP, AG_EVICT, AG_FETCH, AG_UPGRADE, AG_DONE
    } agent_state_t;

    typedef struct packed {
        logic    valid;
        cpu_op_e op;
        word_t   addr;
        word_t   wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic   dREN;
        logic   dWEN;
        logic   ccwrite;
        word_t  daddr;
        block_t dstore;
        logic   ccsnoopdone;
        logic   ccsnoophit;      // line in M or E
        logic   ccIsPresent;
        logic   ccdirty;
    } bus_req_t;

    typedef struct packed {
        logic   dwait;
        block_t dload;
        logic   ccexclusive;
        logic   ccwait;
        logic   ccinv;
        word_t  ccsnoopaddr;
    } bus_rsp_t;

    typedef struct packed {
        logic   l2REN;
        logic   l2WEN;
        word_t  l2addr;
        block_t l2store;
    } l2_req_t;

    typedef struct packed {
        l2_state_t l2state;
        block_t    l2load;
    } l2_rsp_t;
endpackage

/* logic/l2_mem.sv */
module l2_mem (
    input  logic             CLK,
    input  logic             nRST,
    input  coh_pkg::l2_req_t l2_req,
    output coh_pkg::l2_rsp_t l2_rsp
);
    coh_pkg::block_t blocks [coh_pkg::L2_BLOCKS];
    coh_pkg::l2_cnt_t count;            // cycles spent on the current access
    coh_pkg::l2_idx_t idx;
    logic active, access;

    assign idx    = l2_req.l2addr[coh_pkg::BLOCK_OFFSET_W +: coh_pkg::L2_INDEX_W];
    assign active = l2_req.l2REN | l2_req.l2WEN;
    assign access = active && count == coh_pkg::L2_LAST;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
            for (int i = 0; i < coh_pkg::L2_BLOCKS; i++)
                blocks[i] <= '0;
        end else begin
            if (!active || access)
                count <= '0;
            else
                count <= count + 1'b1;
            if (access && l2_req.l2WEN)         // write wins over read
                blocks[idx] <= l2_req.l2store;
        end
    end

    always_comb begin
        if (access)
            l2_rsp.l2state = coh_pkg::L2_ACCESS;
        else if (active)
            l2_rsp.l2state = coh_pkg::L2_BUSY;
        else
            l2_rsp.l2state = coh_pkg::L2_FREE;
        l2_rsp.l2load = blocks[idx];    // sampled by the bus in the access cycle
    end
endmodule

/* logic/l1_agent.sv */
module l1_agent (
    input  logic              CLK,
    input  logic              nRST,
    input  coh_pkg::cpu_req_t cpu_req,
    output coh_pkg::cpu_rsp_t cpu_rsp,
    input  coh_pkg::bus_rsp_t bus_rsp,
    output coh_pkg::bus_req_t bus_req
);
    coh_pkg::agent_state_t state;
    coh_pkg::cpu_req_t req;                     // request being served
    coh_pkg::l1_tag_t tags [coh_pkg::L1_SETS];
    coh_pkg::mesi_t mesi [coh_pkg::L1_SETS];
    coh_pkg::block_t data [coh_pkg::L1_SETS];
    coh_pkg::word_t rdata;
    coh_pkg::l1_idx_t idx, sidx;
    coh_pkg::l1_tag_t tag, stag;
    logic wsel;
    logic hit, snoop_match, write_hit, upgrade_done, fill;
    coh_pkg::block_t fill_blk;
    logic snoop_q;                              // ccwait seen last cycle
    coh_pkg::mesi_t snp_state;
    coh_pkg::block_t snp_data;

    assign idx  = req.addr[coh_pkg::BLOCK_OFFSET_W +: coh_pkg::L1_INDEX_W];
    assign tag  = req.addr[coh_pkg::BLOCK_OFFSET_W + coh_pkg::L1_INDEX_W +: coh_pkg::L1_TAG_W];
    assign wsel = req.addr[coh_pkg::BLOCK_OFFSET_W-1];
    assign sidx = bus_rsp.ccsnoopaddr[coh_pkg::BLOCK_OFFSET_W +: coh_pkg::L1_INDEX_W];
    assign stag = bus_rsp.ccsnoopaddr[coh_pkg::BLOCK_OFFSET_W + coh_pkg::L1_INDEX_W +:
                                      coh_pkg::L1_TAG_W];

    assign hit          = mesi[idx] != coh_pkg::I && tags[idx] == tag;
    assign snoop_match  = mesi[sidx] != coh_pkg::I && tags[sidx] == stag;
    assign write_hit    = state == coh_pkg::AG_LOOKUP && !bus_rsp.ccwait && hit &&
                          req.op == coh_pkg::OP_WRITE && mesi[idx] != coh_pkg::S;
    assign upgrade_done = state == coh_pkg::AG_UPGRADE && !bus_rsp.dwait;
    assign fill         = state == coh_pkg::AG_FETCH && !bus_rsp.dwait;

    always_comb begin
        fill_blk = bus_rsp.dload;
        if (req.op == coh_pkg::OP_WRITE)
            fill_blk[wsel] = req.wdata;     // merge the store word
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state   <= coh_pkg::AG_IDLE;
            snoop_q <= 1'b0;
            for (int i = 0; i < coh_pkg::L1_SETS; i++)
                mesi[i] <= coh_pkg::I;
        end else begin
            snoop_q <= bus_rsp.ccwait;
            case (state)
                coh_pkg::AG_IDLE: if (cpu_req.valid) state <= coh_pkg::AG_LOOKUP;
                coh_pkg::AG_LOOKUP: begin
                    if (!bus_rsp.ccwait) begin  // hold off while a snoop owns the lines
                        if (hit && (req.op == coh_pkg::OP_READ || mesi[idx] != coh_pkg::S)) begin
                            if (req.op == coh_pkg::OP_WRITE)
                                mesi[idx] <= coh_pkg::M;
                            state <= coh_pkg::AG_DONE;
                        end else if (hit)
                            state <= coh_pkg::AG_UPGRADE;
                        else if (mesi[idx] == coh_pkg::M)
                            state <= coh_pkg::AG_EVICT;
                        else
                            state <= coh_pkg::AG_FETCH;
                    end
                end
                coh_pkg::AG_EVICT: begin
                    if (!bus_rsp.dwait) begin
                        mesi[idx] <= coh_pkg::I;
                        state     <= coh_pkg::AG_FETCH;
                    end else if (mesi[idx] != coh_pkg::M)
                        state <= coh_pkg::AG_FETCH;     // a snoop took the victim
                end
                coh_pkg::AG_FETCH: begin
                    if (!bus_rsp.dwait) begin
                        if (req.op == coh_pkg::OP_WRITE)
                            mesi[idx] <= coh_pkg::M;
                        else
                            mesi[idx] <= bus_rsp.ccexclusive ? coh_pkg::E : coh_pkg::S;
                        state <= coh_pkg::AG_DONE;
                    end
                end
                coh_pkg::AG_UPGRADE: begin
                    if (!bus_rsp.dwait) begin
                        mesi[idx] <= coh_pkg::M;
                        state     <= coh_pkg::AG_DONE;
                    end else if (mesi[idx] == coh_pkg::I)
                        state <= coh_pkg::AG_FETCH;     // lost the line, read it for ownership
                end
                default: state <= coh_pkg::AG_IDLE;
            endcase
            // first snoop cycle: invalidate or demote to shared
            if (bus_rsp.ccwait && !snoop_q && snoop_match)
                mesi[sidx] <= bus_rsp.ccinv ? coh_pkg::I : coh_pkg::S;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == coh_pkg::AG_IDLE && cpu_req.valid)
            req <= cpu_req;
        if (fill) begin
            tags[idx] <= tag;
            data[idx] <= fill_blk;
            rdata     <= bus_rsp.dload[wsel];
        end else if (write_hit || upgrade_done)
            data[idx][wsel] <= req.wdata;
        else if (state == coh_pkg::AG_LOOKUP)
            rdata <= data[idx][wsel];
        if (bus_rsp.ccwait && !snoop_q) begin
            snp_state <= snoop_match ? mesi[sidx] : coh_pkg::I;
            snp_data  <= data[sidx];
        end
    end

    always_comb begin
        bus_req.dREN        = state == coh_pkg::AG_FETCH;
        bus_req.dWEN        = state == coh_pkg::AG_EVICT;
        bus_req.ccwrite     = state == coh_pkg::AG_UPGRADE ||
                              (state == coh_pkg::AG_FETCH && req.op == coh_pkg::OP_WRITE);
        bus_req.daddr       = (state == coh_pkg::AG_EVICT) ?
                              {tags[idx], idx, coh_pkg::blk_off_t'(0)} :
                              req.addr & coh_pkg::BLOCK_MASK;
        bus_req.dstore      = snoop_q ? snp_data : data[idx];
        bus_req.ccsnoopdone = snoop_q && bus_rsp.ccwait;
        bus_req.ccsnoophit  = bus_req.ccsnoopdone &&
                              (snp_state == coh_pkg::M || snp_state == coh_pkg::E);
        bus_req.ccIsPresent = bus_req.ccsnoopdone && snp_state != coh_pkg::I;
        bus_req.ccdirty     = bus_req.ccsnoopdone && snp_state == coh_pkg::M;
        cpu_rsp.done        = state == coh_pkg::AG_DONE;
        cpu_rsp.rdata       = rdata;
    end
endmodule

/* logic/bus_ctrl.sv */
module bus_ctrl (
    input  logic              CLK,
    input  logic              nRST,
    input  coh_pkg::bus_req_t bus_req [coh_pkg::CPUS],
    output coh_pkg::bus_rsp_t bus_rsp [coh_pkg::CPUS],
    input  coh_pkg::l2_rsp_t  l2_rsp,
    output coh_pkg::l2_req_t  l2_req
);
    coh_pkg::bus_state_t state, nstate;
    coh_pkg::cpu_id_t requester, nrequester;
    coh_pkg::cpu_id_t supplier, nsupplier;
    logic excl_q, nexcl;            // fill goes to E, no other copy seen
    logic evict_q;                  // current writeback is an eviction
    coh_pkg::word_t snoop_addr, nsnoop_addr;
    coh_pkg::block_t dload_q, ndload;
    coh_pkg::word_t l2_addr, nl2_addr;
    coh_pkg::block_t l2_store, nl2_store;
    logic [coh_pkg::CPUS-1:0] dren, dwen, ccwr, rdx;
    logic [coh_pkg::CPUS-1:0] snoopdone, snoophit, present, dirty;
    logic [coh_pkg::CPUS-1:0] dwait, ccwait, ccinv, ccexcl;
    logic l2_ren, l2_wen, l2_access;

    // lowest set bit wins
    function automatic coh_pkg::cpu_id_t prio_enc(input logic [coh_pkg::CPUS-1:0] vec);
        prio_enc = '0;
        for (int i = coh_pkg::CPUS - 1; i >= 0; i--) begin
            if (vec[i])
                prio_enc = coh_pkg::cpu_id_t'(i);
        end
    endfunction

    function automatic logic [coh_pkg::CPUS-1:0] others(input coh_pkg::cpu_id_t id);
        others = '1;
        others[id] = 1'b0;
    endfunction

    // every non-requester has answered
    function automatic logic snoop_done(input coh_pkg::cpu_id_t id,
                                        input logic [coh_pkg::CPUS-1:0] done);
        snoop_done = &(done | ~others(id));
    endfunction

    always_comb begin
        for (int i = 0; i < coh_pkg::CPUS; i++) begin
            dren[i]      = bus_req[i].dREN;
            dwen[i]      = bus_req[i].dWEN;
            ccwr[i]      = bus_req[i].ccwrite;
            snoopdone[i] = bus_req[i].ccsnoopdone;
            snoophit[i]  = bus_req[i].ccsnoophit;
            present[i]   = bus_req[i].ccIsPresent;
            dirty[i]     = bus_req[i].ccdirty;
        end
    end

    assign rdx       = dren & ccwr;
    assign l2_access = l2_rsp.l2state == coh_pkg::L2_ACCESS;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= coh_pkg::IDLE;
            requester <= '0;
            supplier  <= '0;
            excl_q    <= 1'b0;
            evict_q   <= 1'b0;
        end else begin
            state     <= nstate;
            requester <= nrequester;
            supplier  <= nsupplier;
            excl_q    <= nexcl;
            if (state == coh_pkg::IDLE)
                evict_q <= 1'b0;
            else if (state == coh_pkg::GRANT_EVICT)
                evict_q <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        snoop_addr <= nsnoop_addr;
        dload_q    <= ndload;
        l2_addr    <= nl2_addr;
        l2_store   <= nl2_store;
    end

    always_comb begin
        nstate = state;
        case (state)
            coh_pkg::IDLE: begin
                if (|dwen)
                    nstate = coh_pkg::GRANT_EVICT;
                else if (|rdx)
                    nstate = coh_pkg::GRANT_RX;
                else if (|dren)
                    nstate = coh_pkg::GRANT_R;
                else if (|ccwr)
                    nstate = coh_pkg::GRANT_INV;
            end
            coh_pkg::GRANT_R:     nstate = coh_pkg::SNOOP_R;
            coh_pkg::GRANT_RX:    nstate = coh_pkg::SNOOP_RX;
            coh_pkg::GRANT_EVICT: nstate = coh_pkg::WRITEBACK;
            coh_pkg::GRANT_INV:   nstate = coh_pkg::SNOOP_INV;
            coh_pkg::SNOOP_R: begin
                if (snoop_done(requester, snoopdone))
                    nstate = |snoophit ? coh_pkg::TRANSFER_R : coh_pkg::READ_L2;
            end
            coh_pkg::SNOOP_RX: begin
                if (snoop_done(requester, snoopdone))
                    nstate = |snoophit ? coh_pkg::TRANSFER_RX : coh_pkg::READ_L2;
            end
            coh_pkg::SNOOP_INV: begin
                if (snoop_done(requester, snoopdone))
                    nstate = coh_pkg::INVALIDATE;
            end
            coh_pkg::TRANSFER_R:
                nstate = dirty[supplier] ? coh_pkg::WRITEBACK_MS : coh_pkg::BUS_TO_CACHE;
            coh_pkg::TRANSFER_RX: nstate = coh_pkg::BUS_TO_CACHE;
            coh_pkg::READ_L2:     if (l2_access) nstate = coh_pkg::BUS_TO_CACHE;
            coh_pkg::WRITEBACK_MS:
                nstate = l2_access ? coh_pkg::IDLE : coh_pkg::WRITEBACK;
            coh_pkg::WRITEBACK:   if (l2_access) nstate = coh_pkg::IDLE;
            default:              nstate = coh_pkg::IDLE;   // BUS_TO_CACHE, INVALIDATE
        endcase
    end

    always_comb begin
        nrequester  = requester;
        nsupplier   = supplier;
        nexcl       = excl_q;
        nsnoop_addr = snoop_addr;
        ndload      = dload_q;
        nl2_addr    = l2_addr;
        nl2_store   = l2_store;
        dwait       = '1;
        ccwait      = '0;
        ccinv       = '0;
        ccexcl      = '0;
        l2_ren      = 1'b0;
        l2_wen      = 1'b0;
        case (state)
            coh_pkg::IDLE: begin    // pick the requester by class
                if (|dwen)
                    nrequester = prio_enc(dwen);
                else if (|rdx)
                    nrequester = prio_enc(rdx);
                else if (|dren)
                    nrequester = prio_enc(dren);
                else if (|ccwr)
                    nrequester = prio_enc(ccwr);
            end
            coh_pkg::GRANT_R, coh_pkg::GRANT_RX, coh_pkg::GRANT_INV:
                nsnoop_addr = bus_req[requester].daddr & coh_pkg::BLOCK_MASK;
            coh_pkg::GRANT_EVICT: begin
                nl2_store = bus_req[requester].dstore;
                nl2_addr  = bus_req[requester].daddr & coh_pkg::BLOCK_MASK;
            end
            coh_pkg::SNOOP_R, coh_pkg::SNOOP_RX: begin
                nexcl     = !(|present);
                ccwait    = others(requester);
                ccinv     = (state == coh_pkg::SNOOP_RX) ? others(requester) : '0;
                nsupplier = prio_enc(snoophit);
                nl2_addr  = bus_req[requester].daddr & coh_pkg::BLOCK_MASK;
            end
            coh_pkg::SNOOP_INV: begin
                ccwait = others(requester);
                ccinv  = others(requester);
            end
            coh_pkg::TRANSFER_R: begin  // dirty data also heads for L2
                ccwait    = others(requester);
                ndload    = bus_req[supplier].dstore;
                nl2_store = bus_req[supplier].dstore;
            end
            coh_pkg::TRANSFER_RX: begin
                ccwait = others(requester);
                ndload = bus_req[supplier].dstore;
            end
            coh_pkg::READ_L2: begin
                l2_ren = 1'b1;
                ndload = l2_rsp.l2load;
            end
            coh_pkg::BUS_TO_CACHE: begin
                dwait[requester]  = 1'b0;
                ccexcl[requester] = excl_q;
            end
            coh_pkg::WRITEBACK_MS: begin    // requester released, L2 write continues
                l2_wen            = 1'b1;
                dwait[requester]  = 1'b0;
                ccexcl[requester] = excl_q;
            end
            coh_pkg::WRITEBACK: begin
                l2_wen = 1'b1;
                if (evict_q && l2_access)
                    dwait[requester] = 1'b0;
            end
            coh_pkg::INVALIDATE: dwait[requester] = 1'b0;
            default: ;
        endcase
    end

    always_comb begin
        for (int i = 0; i < coh_pkg::CPUS; i++) begin
            bus_rsp[i].dwait       = dwait[i];
            bus_rsp[i].dload       = dload_q;
            bus_rsp[i].ccexclusive = ccexcl[i];
            bus_rsp[i].ccwait      = ccwait[i];
            bus_rsp[i].ccinv       = ccinv[i];
            bus_rsp[i].ccsnoopaddr = (requester == coh_pkg::cpu_id_t'(i)) ? '0 : snoop_addr;
        end
        l2_req.l2REN   = l2_ren;
        l2_req.l2WEN   = l2_wen;
        l2_req.l2addr  = l2_addr;
        l2_req.l2store = l2_store;
    end
endmodule

/* logic/coherence_top.sv */
module coherence_top (
    input  logic              CLK,
    input  logic              nRST,
    input  coh_pkg::cpu_req_t cpu_req [coh_pkg::CPUS],
    output coh_pkg::cpu_rsp_t cpu_rsp [coh_pkg::CPUS]
);
    coh_pkg::bus_req_t bus_req [coh_pkg::CPUS];
    coh_pkg::bus_rsp_t bus_rsp [coh_pkg::CPUS];
    coh_pkg::l2_req_t  l2_req;
    coh_pkg::l2_rsp_t  l2_rsp;

    // one private cache per processor
    for (genvar i = 0; i < coh_pkg::CPUS; i++) begin : agent_g
        l1_agent agent_i (
            .CLK     (CLK),
            .nRST    (nRST),
            .cpu_req (cpu_req[i]),
            .cpu_rsp (cpu_rsp[i]),
            .bus_rsp (bus_rsp[i]),
            .bus_req (bus_req[i])
        );
    end

    bus_ctrl bus_ctrl_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .l2_rsp  (l2_rsp),
        .l2_req  (l2_req)
    );

    l2_mem l2_i (
        .CLK    (CLK),
        .nRST   (nRST),
        .l2_req (l2_req),
        .l2_rsp (l2_rsp)
    );
endmodule

/* bench/bus_properties.sv */
module bus_properties (
    input logic                     CLK,
    input logic                     nRST,
    input coh_pkg::bus_state_t      state,
    input coh_pkg::cpu_id_t         requester,
    input logic [coh_pkg::CPUS-1:0] dwait,
    input logic [coh_pkg::CPUS-1:0] ccwait,
    input logic [coh_pkg::CPUS-1:0] ccinv
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;     // seen by the testbench checker

    one_grant: assert property (@(posedge CLK) disable iff (!nRST)
        $countones(~dwait) <= 1)
        else begin
            fail_count++;
            $error("more than one dwait low in a cycle");
        end

    // the requester never invalidates its own line
    no_self_inv: assert property (@(posedge CLK) disable iff (!nRST)
        !ccinv[requester])
        else begin
            fail_count++;
            $error("ccinv high for the requester");
        end

    snoop_after_grant: assert property (@(posedge CLK) disable iff (!nRST)
        (state inside {coh_pkg::GRANT_R, coh_pkg::GRANT_RX, coh_pkg::GRANT_INV}) |=> |ccwait)
        else begin
            fail_count++;
            $error("ccwait low after a snooping grant");
        end
endmodule

/* bench/coherence_tb.sv */
module coherence_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RANDOM_PER_CPU = 100;
    localparam int RANDOM_OPS     = RANDOM_PER_CPU * coh_pkg::CPUS;
    localparam int DIRECTED_OPS   = 15;
    localparam int TIMEOUT_CYCLES = (DIRECTED_OPS + RANDOM_OPS) * 40;
    localparam int MODEL_WORDS    = 32;     // 16 blocks of two words

    logic CLK;
    logic nRST;
    coh_pkg::cpu_req_t cpu_req [coh_pkg::CPUS];
    coh_pkg::cpu_rsp_t cpu_rsp [coh_pkg::CPUS];

    coh_pkg::word_t model [MODEL_WORDS];              // last value written per word
    coh_pkg::cpu_req_t pending [coh_pkg::CPUS];       // request each port waits on
    coh_pkg::cpu_req_t rnd_req [coh_pkg::CPUS][RANDOM_PER_CPU];
    logic [coh_pkg::CPUS-1:0] busy;
    int issued [coh_pkg::CPUS];
    int completed [coh_pkg::CPUS];
    logic [15:0] lfsr;
    string test_name;

    coherence_top dut_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp)
    );

    bind bus_ctrl bus_properties props_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .state     (state),
        .requester (requester),
        .dwait     (dwait),
        .ccwait    (ccwait),
        .ccinv     (ccinv)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // fibonacci lfsr on taps 16 14 13 11 stepped once per bit
    function automatic coh_pkg::word_t random_bits(input int n);
        logic fb;
        random_bits = '0;
        for (int b = 0; b < n; b++) begin
            fb          = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr        = {lfsr[14:0], fb};
            random_bits = {random_bits[30:0], fb};
        end
    endfunction

    // every read sees the latest completed write
    function automatic coh_pkg::word_t expected_word(input coh_pkg::word_t addr);
        return model[addr[6:2]];
    endfunction

    task automatic check_word(input string name, input coh_pkg::word_t exp,
                              input coh_pkg::word_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("tests failed");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic check_done(input string name, input coh_pkg::cpu_rsp_t exp,
                              input coh_pkg::cpu_rsp_t act);
        if (act.done !== exp.done) begin
            $display("Fail %s: expected done %b, actual done %b", name, exp.done, act.done);
            $display("tests failed");
            $fatal(1, "unexpected done pulse");
        end
    endtask

    task automatic issue(input int port, input coh_pkg::cpu_op_e op,
                         input coh_pkg::word_t addr, input coh_pkg::word_t wdata);
        @(negedge CLK);
        while (busy[port])
            @(negedge CLK);
        cpu_req[port].valid = 1'b1;
        cpu_req[port].op    = op;
        cpu_req[port].addr  = addr;
        cpu_req[port].wdata = wdata;
        pending[port]       = cpu_req[port];
        busy[port]          = 1'b1;
        issued[port]++;
        @(negedge CLK);
        cpu_req[port].valid = 1'b0;     // one cycle strobe
    endtask

    task automatic run_op(input int port, input coh_pkg::cpu_op_e op,
                          input coh_pkg::word_t addr, input coh_pkg::word_t wdata);
        issue(port, op, addr, wdata);
        while (busy[port])
            @(negedge CLK);
    endtask

    task automatic build_random_ops();
        coh_pkg::word_t addr_bits;
        for (int k = 0; k < RANDOM_PER_CPU; k++) begin
            for (int p = 0; p < coh_pkg::CPUS; p++) begin
                rnd_req[p][k].valid = 1'b1;
                rnd_req[p][k].op    = random_bits(1) ? coh_pkg::OP_WRITE : coh_pkg::OP_READ;
                addr_bits           = random_bits(5);   // block and word select
                rnd_req[p][k].addr  = addr_bits << 2;
                rnd_req[p][k].wdata = random_bits(32);
            end
        end
    endtask

    task automatic drive_random(input int port);
        for (int k = 0; k < RANDOM_PER_CPU; k++)
            issue(port, rnd_req[port][k].op, rnd_req[port][k].addr, rnd_req[port][k].wdata);
    endtask

    // done and rdata come from registers and hold across the edge
    always @(posedge CLK) begin
        coh_pkg::cpu_rsp_t exp_rsp;
        if (nRST === 1'b1) begin
            if (dut_i.bus_ctrl_i.props_i.fail_count != 0) begin
                $display("a bus controller assertion failed during %s", test_name);
                $display("tests failed");
                $fatal(1, "assertion failure");
            end
            for (int i = 0; i < coh_pkg::CPUS; i++) begin
                if (cpu_rsp[i].done !== 1'b0) begin
                    exp_rsp.done  = busy[i];
                    exp_rsp.rdata = expected_word(pending[i].addr);
                    check_done(test_name, exp_rsp, cpu_rsp[i]);
                    if (pending[i].op == coh_pkg::OP_READ)
                        check_word(test_name, exp_rsp.rdata, cpu_rsp[i].rdata);
                end
            end
            // writes land after the reads finishing in the same cycle
            for (int i = 0; i < coh_pkg::CPUS; i++) begin
                if (cpu_rsp[i].done === 1'b1) begin
                    if (pending[i].op == coh_pkg::OP_WRITE)
                        model[pending[i].addr[6:2]] = pending[i].wdata;
                    busy[i] = 1'b0;
                    completed[i]++;
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES + 10) @(posedge CLK);
        $display("a processor never completed its request during %s", test_name);
        $display("tests failed");
        $fatal(1, "timeout");
    end

    initial begin
        int missing;
        nRST      = 1'b0;
        busy      = '0;
        lfsr      = 16'd58;
        test_name = "reset";
        for (int i = 0; i < coh_pkg::CPUS; i++) begin
            cpu_req[i]   = '0;
            pending[i]   = '0;
            issued[i]    = 0;
            completed[i] = 0;
        end
        for (int w = 0; w < MODEL_WORDS; w++)
            model[w] = '0;
        build_random_ops();
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        test_name = "reset_read";
        run_op(0, coh_pkg::OP_READ, 32'h00, '0);
        run_op(0, coh_pkg::OP_READ, 32'h00, '0);

        test_name = "shared_read";          // owner supplies first and L2 after
        run_op(1, coh_pkg::OP_WRITE, 32'h08, 32'hA5A5_0001);
        run_op(0, coh_pkg::OP_READ, 32'h08, '0);
        run_op(2, coh_pkg::OP_READ, 32'h08, '0);
        run_op(3, coh_pkg::OP_READ, 32'h08, '0);

        test_name = "upgrade";
        run_op(0, coh_pkg::OP_READ, 32'h10, '0);
        run_op(1, coh_pkg::OP_READ, 32'h10, '0);
        run_op(2, coh_pkg::OP_READ, 32'h10, '0);
        run_op(2, coh_pkg::OP_WRITE, 32'h14, 32'h5A5A_0002);   // hit in S
        run_op(0, coh_pkg::OP_READ, 32'h14, '0);
        run_op(1, coh_pkg::OP_READ, 32'h14, '0);

        test_name = "dirty_evict";          // 0x20 and 0x40 share set 0
        run_op(3, coh_pkg::OP_WRITE, 32'h20, 32'h0BAD_0003);
        run_op(3, coh_pkg::OP_WRITE, 32'h40, 32'h0BAD_0004);
        run_op(1, coh_pkg::OP_READ, 32'h20, '0);

        test_name = "random";
        for (int p = 0; p < coh_pkg::CPUS; p++) begin
            fork
                automatic int port = p;
                drive_random(port);
            join_none
        end
        wait fork;
        while (|busy)
            @(negedge CLK);
        repeat (4) @(negedge CLK);          // room for a stray done

        missing = 0;
        for (int p = 0; p < coh_pkg::CPUS; p++)
            if (completed[p] != issued[p])
                missing++;
        if (missing != 0) begin
            $display("some processor requests did not get exactly one done");
            $display("tests failed");
            $fatal(1, "done count mismatch");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end
endmodule

/* flist.f */
logic/coh_pkg.sv
logic/l2_mem.sv
logic/l1_agent.sv
logic/bus_ctrl.sv
logic/coherence_top.sv
bench/bus_properties.sv
bench/coherence_tb.sv
